/* flist.f */
+incdir+rtl
rtl/power_pkg.sv
rtl/power_lane_if.sv
rtl/power_regs.sv
rtl/power_dispatch.sv
rtl/power_lane.sv
rtl/power_collect.sv
rtl/power_top.sv
bench/power_tb.sv

/* bench/power_tb.sv */
`include "power_settings.svh"

module power_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ACK_LIMIT = 8;
  localparam int IRQ_LIMIT = 2000;

  logic        CLK;
  logic        RST;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [5:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        irq;

  // Expected read data, armed by check_read
  logic        check_en;
  logic [31:0] expected_rd;
  int          data_errs;
  int          proto_errs;
  int          timeouts;

  // Host-side copy of both arrays
  logic [31:0] model_opnd [16];
  logic [31:0] model_rslt [16];
  bit          rslt_known [16];

  power_top dut0 (
    .CLK      (CLK),
    .RST      (RST),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .irq      (irq)
  );

  // 40 ns period
  always #20 CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Checkers
  ////////////////////////////////////////////////////////////

  // Quiet outputs while in reset
  a_reset_quiet: assert property (@(posedge CLK) RST |-> !wb_ack && !irq)
    else begin
      proto_errs++;
      $display("** Error at %0t: wb_ack/irq expected 0/0, got %b/%b",
               $time, $sampled(wb_ack), $sampled(irq));
    end

  // Ack one clock after a new request
  a_ack_rise: assert property (@(posedge CLK) disable iff (RST)
    $rose(wb_cyc && wb_stb) |=> wb_ack)
    else begin
      proto_errs++;
      $display("** Error at %0t: wb_ack expected 1, got %b", $time, $sampled(wb_ack));
    end

  // Single-cycle ack
  a_ack_width: assert property (@(posedge CLK) disable iff (RST) wb_ack |=> !wb_ack)
    else begin
      proto_errs++;
      $display("** Error at %0t: wb_ack expected 0, got %b", $time, $sampled(wb_ack));
    end

  // Read data against the host model
  a_read_data: assert property (@(posedge CLK) disable iff (RST)
    wb_ack && check_en |-> wb_dat_r == expected_rd)
    else begin
      data_errs++;
      $display("** Error at %0t: wb_dat_r expected %h, got %h",
               $time, expected_rd, $sampled(wb_dat_r));
    end

  // Job no longer busy once irq rises
  a_irq_done: assert property (@(posedge CLK) disable iff (RST)
    $rose(irq) |-> !dut0.u_regs.busy)
    else begin
      proto_errs++;
      $display("** Error at %0t: busy expected 0, got %b", $time,
               $sampled(dut0.u_regs.busy));
    end

  // New start drops irq
  a_irq_clear: assert property (@(posedge CLK) disable iff (RST)
    dut0.job_start |-> !irq)
    else begin
      proto_errs++;
      $display("** Error at %0t: irq expected 0, got %b", $time, $sampled(irq));
    end

  ////////////////////////////////////////////////////////////
  // Host tasks and reference model
  ////////////////////////////////////////////////////////////

  task automatic finish_run();
    $display("Errors: %0d data, %0d protocol, %0d timeout", data_errs, proto_errs, timeouts);
    if (data_errs + proto_errs + timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    timeouts++;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  // One classic cycle, strobe held across the acking edge
  task automatic bus_cycle(input logic we, input logic [5:0] adr, input logic [31:0] data);
    int waited;
    waited = 0;
    // Bus stays idle once a wait has run out
    if (timeouts == 0) begin
      @(negedge CLK);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = data;
      do begin
        @(negedge CLK);
        waited++;
      end while (!wb_ack && waited <= ACK_LIMIT);
      if (!wb_ack) begin
        timeout_fail("the DUT never acked a Wishbone cycle");
      end
      @(negedge CLK);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
    end
  endtask

  task automatic check_read(input logic [5:0] adr, input logic [31:0] expected);
    expected_rd = expected;
    check_en    = 1'b1;
    bus_cycle(1'b0, adr, '0);
    check_en    = 1'b0;
  endtask

  task automatic wait_irq();
    int waited;
    waited = 0;
    while (!irq && timeouts == 0 && waited <= IRQ_LIMIT) begin
      @(negedge CLK);
      waited++;
    end
    if (!irq && timeouts == 0) begin
      timeout_fail("irq did not rise at the end of a job");
    end
  endtask

  // Plain repeated product, wraps at 32 bits
  function automatic logic [31:0] ref_power(input logic [31:0] base, input int e);
    logic [31:0] acc;
    acc = 32'd1;
    for (int k = 0; k < e; k++) begin
      acc = acc * base;
    end
    return acc;
  endfunction

  // Load, start, wait, then compare every known result
  task automatic run_job(input int size, input int expo, input bit restart);
    logic [31:0] opnd;
    for (int i = 0; i < size; i++) begin
      opnd          = $urandom();
      model_opnd[i] = opnd;
      bus_cycle(1'b1, `POWER_ADR_OPND + 6'(i), opnd);
    end
    bus_cycle(1'b1, `POWER_ADR_SIZE, 32'(size));
    bus_cycle(1'b1, `POWER_ADR_EXP, 32'(expo));
    bus_cycle(1'b1, `POWER_ADR_CTRL, 32'd1);
    if (restart) begin
      // Busy mid-job, then a start that must be ignored
      check_read(`POWER_ADR_STATUS, 32'd1);
      bus_cycle(1'b1, `POWER_ADR_CTRL, 32'd1);
    end
    wait_irq();
    check_read(`POWER_ADR_STATUS, 32'd2);
    for (int i = 0; i < size; i++) begin
      model_rslt[i] = ref_power(model_opnd[i], expo);
      rslt_known[i] = 1'b1;
    end
    for (int i = 0; i < 16; i++) begin
      if (rslt_known[i]) begin
        check_read(`POWER_ADR_RSLT + 6'(i), model_rslt[i]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int size_r;
    int exp_r;
    void'($urandom(26));
    CLK         = 1'b0;
    RST         = 1'b1;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    check_en    = 1'b0;
    expected_rd = '0;
    data_errs   = 0;
    proto_errs  = 0;
    timeouts    = 0;
    for (int i = 0; i < 16; i++) begin
      rslt_known[i] = 1'b0;
    end
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Idle register block
    check_read(6'd5, 32'd0);
    check_read(`POWER_ADR_STATUS, 32'd0);
    bus_cycle(1'b1, `POWER_ADR_SIZE, 32'd20);
    check_read(`POWER_ADR_SIZE, 32'd16);
    bus_cycle(1'b1, `POWER_ADR_SIZE, 32'd7);
    check_read(`POWER_ADR_SIZE, 32'd7);
    bus_cycle(1'b1, `POWER_ADR_EXP, 32'h0000_00ab);
    check_read(`POWER_ADR_EXP, 32'h0000_00ab);

    // Edge exponents
    run_job(16, 0, 1'b0);
    run_job(9, 1, 1'b0);

    // Random jobs
    repeat (8) begin
      size_r = $urandom_range(16, 1);
      exp_r  = $urandom_range(255, 0);
      run_job(size_r, exp_r, 1'b0);
    end

    // Long job with a stray start
    exp_r = 128 + $urandom_range(127, 0);
    run_job(16, exp_r, 1'b1);

    // Empty job leaves results alone
    exp_r = $urandom_range(255, 0);
    run_job(0, exp_r, 1'b0);

    finish_run();
  end

endmodule

/* rtl/power_top.sv */
`include "power_settings.svh"

module power_top (
  input  logic        CLK,
  input  logic        RST,
  // Wishbone classic slave
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [5:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  output logic        irq
);

  import power_pkg::*;

  // Job control from the register block
  logic         job_start;
  power_size_t  job_size;
  power_exp_t   job_exp;
  // Operand fetch
  power_index_t opnd_index;
  power_data_t  opnd_data;
  // Result write back
  logic         rslt_we;
  power_index_t rslt_index;
  power_data_t  rslt_data;
  logic         job_done;

  // Lane links shared by dispatcher, lanes and collector
  power_lane_if lane_bus [`POWER_LANES] ();

  ////////////////////////////////////////////////////////////
  // Register block
  ////////////////////////////////////////////////////////////

  power_regs u_regs (
    .CLK        (CLK),
    .RST        (RST),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .irq        (irq),
    .job_start  (job_start),
    .job_size   (job_size),
    .job_exp    (job_exp),
    .opnd_index (opnd_index),
    .opnd_data  (opnd_data),
    .rslt_we    (rslt_we),
    .rslt_index (rslt_index),
    .rslt_data  (rslt_data),
    .job_done   (job_done)
  );

  ////////////////////////////////////////////////////////////
  // Dispatch, lanes, collect
  ////////////////////////////////////////////////////////////

  power_dispatch u_dispatch (
    .CLK        (CLK),
    .RST        (RST),
    .job_start  (job_start),
    .job_size   (job_size),
    .opnd_index (opnd_index),
    .opnd_data  (opnd_data),
    .lanes      (lane_bus)
  );

  // Both halves of a lane ride on the same link
  for (genvar g = 0; g < `POWER_LANES; g++) begin : g_lane
    power_lane u_lane (
      .CLK (CLK),
      .RST (RST),
      .exp (job_exp),
      .req (lane_bus[g]),
      .rsp (lane_bus[g])
    );
  end

  power_collect u_collect (
    .CLK        (CLK),
    .RST        (RST),
    .job_start  (job_start),
    .job_size   (job_size),
    .lanes      (lane_bus),
    .rslt_we    (rslt_we),
    .rslt_index (rslt_index),
    .rslt_data  (rslt_data),
    .job_done   (job_done)
  );

endmodule

/* rtl/power_collect.sv */
`include "power_settings.svh"

module power_collect (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    job_start,
  input  power_pkg::power_size_t  job_size,
  // One response port per lane
  power_lane_if.coll              lanes [`POWER_LANES],
  // Result array write port
  output logic                    rslt_we,
  output power_pkg::power_index_t rslt_index,
  output power_pkg::power_data_t  rslt_data,
  output logic                    job_done
);

  import power_pkg::*;

  logic [`POWER_LANES-1:0] valid_vec;
  power_data_t             result_arr [`POWER_LANES];
  power_index_t            index_arr  [`POWER_LANES];
  power_lane_t             rr_ptr;
  power_lane_t             sel;
  logic                    found;
  power_size_t             done_cnt;

  for (genvar i = 0; i < `POWER_LANES; i++) begin : g_lane
    assign valid_vec[i]       = lanes[i].rsp_valid;
    assign result_arr[i]      = lanes[i].rsp_result;
    assign index_arr[i]       = lanes[i].rsp_index;
    assign lanes[i].rsp_ready = found && (sel == power_lane_t'(i));
  end

  ////////////////////////////////////////////////////////////
  // Round-robin arbiter
  ////////////////////////////////////////////////////////////

  // Search starts at the lane after the last grant
  always_comb begin
    power_lane_t cand;
    found = 1'b0;
    sel   = rr_ptr;
    for (int k = 0; k < `POWER_LANES; k++) begin
      cand = rr_ptr + power_lane_t'(k);
      if (!found && valid_vec[cand]) begin
        found = 1'b1;
        sel   = cand;
      end
    end
  end

  // Write back in the granting cycle
  assign rslt_we    = found;
  assign rslt_index = index_arr[sel];
  assign rslt_data  = result_arr[sel];

  // Completion count
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rr_ptr   <= '0;
      done_cnt <= '0;
      job_done <= 1'b0;
    end else begin
      job_done <= 1'b0;
      if (job_start) begin
        done_cnt <= '0;
        job_done <= (job_size == '0);
      end else if (found) begin
        rr_ptr   <= sel + 1'b1;
        done_cnt <= done_cnt + 1'b1;
        if (power_size_t'(done_cnt + 1'b1) == job_size) begin
          job_done <= 1'b1;
        end
      end
    end
  end

endmodule

/* rtl/power_lane.sv */
module power_lane (
  input  logic                  CLK,
  input  logic                  RST,
  input  power_pkg::power_exp_t exp,
  power_lane_if.lane            req,
  power_lane_if.lane            rsp
);

  import power_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    HOLD
  } state_t;

  state_t       state;
  logic         load;
  power_data_t  base_q;
  power_data_t  acc_q;
  power_exp_t   exp_q;
  power_index_t tag_q;

  ////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////

  // Accept only when empty
  assign req.req_ready = (state == IDLE);
  assign load          = req.req_valid && req.req_ready;

  assign rsp.rsp_valid  = (state == HOLD);
  assign rsp.rsp_result = acc_q;
  assign rsp.rsp_index  = tag_q;

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          // Zero exponent skips straight to result 1
          if (load) begin
            state <= (exp == '0) ? HOLD : CALC;
          end
        end
        // Last exponent bit in this cycle
        CALC: begin
          if ((exp_q >> 1) == '0) begin
            state <= HOLD;
          end
        end
        HOLD: begin
          if (rsp.rsp_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Square-and-multiply datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (load) begin
      base_q <= req.req_operand;
      acc_q  <= power_data_t'(1);
      exp_q  <= exp;
      tag_q  <= req.req_index;
    end else if (state == CALC) begin
      // LSB first, products wrap mod 2^32
      if (exp_q[0]) begin
        acc_q <= acc_q * base_q;
      end
      base_q <= base_q * base_q;
      exp_q  <= exp_q >> 1;
    end
  end

  // No second request until the collector took this result
  a_busy_no_ready: assert property (@(posedge CLK) disable iff (RST)
    load |=> !req.req_ready until_with (rsp.rsp_valid && rsp.rsp_ready));

  // Result held steady while the collector stalls
  a_rsp_stable: assert property (@(posedge CLK) disable iff (RST)
    rsp.rsp_valid && !rsp.rsp_ready |=>
      rsp.rsp_valid && $stable(rsp.rsp_result) && $stable(rsp.rsp_index));

endmodule

/* rtl/power_dispatch.sv */
`include "power_settings.svh"

module power_dispatch (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    job_start,
  input  power_pkg::power_size_t  job_size,
  // Operand array lookup
  output power_pkg::power_index_t opnd_index,
  input  power_pkg::power_data_t  opnd_data,
  // One request port per lane
  power_lane_if.disp              lanes [`POWER_LANES]
);

  import power_pkg::*;

  power_size_t             issue_cnt;
  logic                    active;
  logic                    fire;
  logic [`POWER_LANES-1:0] ready_vec;
  logic [`POWER_LANES-1:0] grant;
  logic [`POWER_LANES-1:0] xfer_vec;

  ////////////////////////////////////////////////////////////
  // Lane selection
  ////////////////////////////////////////////////////////////

  // Lowest free lane wins
  always_comb begin
    grant = '0;
    for (int i = `POWER_LANES - 1; i >= 0; i--) begin
      if (active && ready_vec[i]) begin
        grant    = '0;
        grant[i] = 1'b1;
      end
    end
  end

  // Valid only where ready is already high, so every offer transfers at once
  assign fire       = |grant;
  assign opnd_index = power_index_t'(issue_cnt);

  for (genvar i = 0; i < `POWER_LANES; i++) begin : g_lane
    assign ready_vec[i]         = lanes[i].req_ready;
    assign lanes[i].req_valid   = grant[i];
    // Payload broadcast to all lanes
    assign lanes[i].req_operand = opnd_data;
    assign lanes[i].req_index   = opnd_index;
    assign xfer_vec[i]          = lanes[i].req_valid && lanes[i].req_ready;
  end

  ////////////////////////////////////////////////////////////
  // Issue counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      active    <= 1'b0;
      issue_cnt <= '0;
    end else if (job_start) begin
      // Empty job issues nothing
      active    <= (job_size != '0);
      issue_cnt <= '0;
    end else if (fire) begin
      issue_cnt <= issue_cnt + 1'b1;
      if (power_size_t'(issue_cnt + 1'b1) == job_size) begin
        active <= 1'b0;
      end
    end
  end

  // Never two lanes loaded from one operand
  a_one_xfer: assert property (@(posedge CLK) disable iff (RST)
    $onehot0(xfer_vec));

endmodule

/* rtl/power_regs.sv */
`include "power_settings.svh"

module power_regs (
  input  logic                    CLK,
  input  logic                    RST,
  // Wishbone classic slave
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [5:0]              wb_adr,
  input  power_pkg::power_data_t  wb_dat_w,
  output power_pkg::power_data_t  wb_dat_r,
  output logic                    wb_ack,
  output logic                    irq,
  // Job control
  output logic                    job_start,
  output power_pkg::power_size_t  job_size,
  output power_pkg::power_exp_t   job_exp,
  // Operand read port for the dispatcher
  input  power_pkg::power_index_t opnd_index,
  output power_pkg::power_data_t  opnd_data,
  // Result write port for the collector
  input  logic                    rslt_we,
  input  power_pkg::power_index_t rslt_index,
  input  power_pkg::power_data_t  rslt_data,
  input  logic                    job_done
);

  import power_pkg::*;

  logic         wb_req;
  logic         wb_wr;
  logic         is_opnd;
  logic         is_rslt;
  logic         start_req;
  logic         busy;
  logic         done;
  power_index_t win_index;
  power_size_t  size_q;
  power_exp_t   exp_q;
  power_data_t  rd_data;
  power_data_t  opnd_mem [`POWER_MAX_SIZE];
  power_data_t  rslt_mem [`POWER_MAX_SIZE];

  ////////////////////////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////////////////////////

  // New request, not yet acked
  assign wb_req = wb_cyc && wb_stb && !wb_ack;
  assign wb_wr  = wb_req && wb_we;

  assign is_opnd = (wb_adr >= `POWER_ADR_OPND) &&
                   (wb_adr < `POWER_ADR_OPND + `POWER_MAX_SIZE);
  assign is_rslt = (wb_adr >= `POWER_ADR_RSLT) &&
                   (wb_adr < `POWER_ADR_RSLT + `POWER_MAX_SIZE);

  // Low address bits pick the word inside a window
  assign win_index = power_index_t'(wb_adr[3:0]);

  // Start only honoured when idle
  assign start_req = wb_wr && (wb_adr == `POWER_ADR_CTRL) && wb_dat_w[0] && !busy;

  ////////////////////////////////////////////////////////////
  // Control and status
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wb_ack    <= 1'b0;
      job_start <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      size_q    <= '0;
      exp_q     <= '0;
    end else begin
      // Single-cycle ack, one clock after the request
      wb_ack    <= wb_req;
      job_start <= start_req;
      if (start_req) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (job_done) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
      // Job parameters frozen while busy
      if (wb_wr && !busy && (wb_adr == `POWER_ADR_SIZE)) begin
        if (wb_dat_w > `POWER_MAX_SIZE) begin
          size_q <= power_size_t'(`POWER_MAX_SIZE);
        end else begin
          size_q <= power_size_t'(wb_dat_w);
        end
      end
      if (wb_wr && !busy && (wb_adr == `POWER_ADR_EXP)) begin
        exp_q <= power_exp_t'(wb_dat_w);
      end
    end
  end

  assign job_size = size_q;
  assign job_exp  = exp_q;
  assign irq      = done;

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;
    case (wb_adr)
      `POWER_ADR_STATUS: rd_data = power_data_t'({done, busy});
      `POWER_ADR_SIZE:   rd_data = power_data_t'(size_q);
      `POWER_ADR_EXP:    rd_data = power_data_t'(exp_q);
      default: begin
        if (is_opnd) begin
          rd_data = opnd_mem[win_index];
        end else if (is_rslt) begin
          rd_data = rslt_mem[win_index];
        end
      end
    endcase
  end

  // Data captured with the ack
  always_ff @(posedge CLK) begin
    if (wb_req) begin
      wb_dat_r <= rd_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand and result arrays
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (wb_wr && is_opnd) begin
      opnd_mem[win_index] <= wb_dat_w;
    end
  end

  always_ff @(posedge CLK) begin
    if (rslt_we) begin
      rslt_mem[rslt_index] <= rslt_data;
    end
  end

  // Asynchronous read for the dispatcher
  assign opnd_data = opnd_mem[opnd_index];

  // Host keeps strobe up until it sees the ack
  a_ack_with_stb: assert property (@(posedge CLK) disable iff (RST)
    wb_ack |-> wb_cyc && wb_stb);

  // Collector only finishes a job that was started
  a_done_while_busy: assert property (@(posedge CLK) disable iff (RST)
    job_done |-> busy);

endmodule

/* rtl/power_lane_if.sv */
interface power_lane_if;

  import power_pkg::*;

  // Request half, dispatcher to lane
  logic         req_valid;
  logic         req_ready;
  power_data_t  req_operand;
  power_index_t req_index;

  // Response half, lane to collector
  logic         rsp_valid;
  logic         rsp_ready;
  power_data_t  rsp_result;
  power_index_t rsp_index;

  // Dispatcher offers operands
  modport disp (
    output req_valid, req_operand, req_index,
    input  req_ready
  );

  // Lane takes requests and returns results
  modport lane (
    input  req_valid, req_operand, req_index, rsp_ready,
    output req_ready, rsp_valid, rsp_result, rsp_index
  );

  // Collector drains results
  modport coll (
    input  rsp_valid, rsp_result, rsp_index,
    output rsp_ready
  );

endinterface

/* rtl/power_pkg.sv */
`include "power_settings.svh"

package power_pkg;

  ////////////////////////////////////////////////////////////
  // Element types
  ////////////////////////////////////////////////////////////

  // Operand and result value
  typedef logic [`POWER_DATA_W-1:0] power_data_t;

  // Position of an element in the vector
  typedef logic [$clog2(`POWER_MAX_SIZE)-1:0] power_index_t;

  // Vector length, one wider than the index so a full vector fits
  typedef logic [$clog2(`POWER_MAX_SIZE+1)-1:0] power_size_t;

  ////////////////////////////////////////////////////////////
  // Job and lane types
  ////////////////////////////////////////////////////////////

  // Common exponent for the whole job
  typedef logic [`POWER_EXP_W-1:0] power_exp_t;

  // Lane number for dispatch and arbitration
  typedef logic [$clog2(`POWER_LANES)-1:0] power_lane_t;

endpackage

/* rtl/power_settings.svh */
`ifndef POWER_SETTINGS_SVH
`define POWER_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////////////////////////

// Element width, shared with the Wishbone data bus
`define POWER_DATA_W   32
// Exponent register width
`define POWER_EXP_W    8
// Parallel power engines
`define POWER_LANES    4
// Longest vector the arrays can hold
`define POWER_MAX_SIZE 16

////////////////////////////////////////////////////////////
// Register map in words
////////////////////////////////////////////////////////////

`define POWER_ADR_CTRL   6'd0
`define POWER_ADR_STATUS 6'd1
`define POWER_ADR_SIZE   6'd2
`define POWER_ADR_EXP    6'd3
// Array windows, both 16-word aligned
`define POWER_ADR_OPND   6'd16
`define POWER_ADR_RSLT   6'd32

`endif
